/* logic/core_pkg.sv */
package core_pkg;

  localparam int WORD_W    = 16;  // memory and register width
  localparam int ADDR_W    = 6;   // word address width
  localparam int REG_IDX_W = 5;   // register number width
  localparam int RAM_WORDS = 64;  // memory depth
  localparam int NUM_REGS  = 32;  // register file size

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [7:0]           opcode_t;  // upper byte of word 1

  localparam opcode_t OPCODE_HALT    = 8'd0;  // clears the run bit
  localparam opcode_t OPCODE_JMP     = 8'd1;  // absolute jump
  localparam opcode_t OPCODE_RAM2REG = 8'd2;  // mem -> reg
  localparam opcode_t OPCODE_REG2RAM = 8'd3;  // reg -> mem
  localparam opcode_t OPCODE_NUM2REG = 8'd4;  // immediate -> reg

  localparam addr_t PROGRAM_BASE = 6'd46;  // first fetch after start

  // host map, bytes 0x000..0x0fc are memory words
  localparam logic [11:0] CTRL_ADDR = 12'h100;  // run bit at bit 0

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // second instruction word, immediate or memory address
  typedef union packed {
    word_t imm;  // NUM2REG value
    struct packed {
      logic [WORD_W-ADDR_W-1:0] unused;  // ignored upper bits
      addr_t                    addr;    // JMP target or load/store address
    } mem;
  } operand_u;

endpackage

/* logic/word_ram.sv */
`timescale 1ns/1ps

module word_ram (
  input  logic            clk,
  input  logic            host_en,
  input  logic            host_we,
  input  core_pkg::addr_t host_addr,
  input  core_pkg::word_t host_wdata,
  input  logic            ex_en,
  input  logic            ex_we,
  input  core_pkg::addr_t ex_addr,
  input  core_pkg::word_t ex_wdata,
  input  logic            fetch_en,
  input  core_pkg::addr_t fetch_addr,
  output core_pkg::word_t rdata,
  output logic            fetch_grant
);

  import core_pkg::*;

  word_t mem [RAM_WORDS];  // no reset, contents survive rst

  logic  sel_en;     // some requester active
  logic  sel_we;     // winning request writes
  addr_t sel_addr;   // winning address
  word_t sel_wdata;  // winning write data

  // fixed priority: host, then execute, then fetch
  always_comb begin
    sel_en    = 1'b1;
    sel_we    = 1'b0;
    sel_addr  = fetch_addr;
    sel_wdata = ex_wdata;
    if (host_en) begin
      sel_we    = host_we;
      sel_addr  = host_addr;
      sel_wdata = host_wdata;
    end else if (ex_en) begin
      sel_we    = ex_we;
      sel_addr  = ex_addr;
    end else if (!fetch_en) begin
      sel_en    = 1'b0;  // idle cycle, rdata holds
    end
  end

  // fetch retries until it wins a cycle
  assign fetch_grant = fetch_en && !host_en && !ex_en;

  // single port, read-before-write
  always_ff @(posedge clk) begin
    if (sel_en) begin
      if (sel_we) begin
        mem[sel_addr] <= sel_wdata;
      end
      rdata <= mem[sel_addr];  // valid the cycle after the grant
    end
  end

endmodule

/* logic/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
  input  logic            clk,
  input  logic            rst,
  input  logic            start,
  input  logic            running,
  output logic            fetch_en,
  output core_pkg::addr_t fetch_addr,
  input  logic            fetch_grant,
  input  core_pkg::word_t rdata,
  output logic            instr_valid,
  output core_pkg::word_t instr_word1,
  output core_pkg::word_t instr_word2,
  output core_pkg::addr_t instr_pc,
  input  logic            instr_ready,
  input  logic            redirect,
  input  core_pkg::addr_t redirect_pc
);

  import core_pkg::*;

  addr_t pc;         // next word to request, wraps at 64
  logic  half;       // 0 = next request is word 1, 1 = word 2
  logic  pend;       // read granted last cycle, rdata is ours
  logic  pend_half;  // which word that read was
  logic  valid_q;    // output pair held for execute
  word_t word1_q;    // word 1 waiting for its partner
  addr_t pair_pc;    // address of the pair being assembled
  logic  flush;      // drop everything in flight
  logic  out_free;   // output slot empty by next cycle
  logic  load_pair;  // word 2 arriving, pair complete

  assign flush     = start || redirect || !running;
  assign out_free  = !valid_q || instr_ready;
  assign load_pair = pend && pend_half && !flush;

  // word 2 only goes out when its slot is sure to be free
  assign fetch_en    = !flush && (!half || out_free);
  assign fetch_addr  = pc;
  assign instr_valid = valid_q && running;  // masks the pair after halt

  always_ff @(posedge clk) begin
    if (rst) begin
      pc      <= PROGRAM_BASE;
      half    <= 1'b0;
      pend    <= 1'b0;
      valid_q <= 1'b0;
    end else if (flush) begin
      if (start) begin
        pc <= PROGRAM_BASE;
      end else if (redirect) begin
        pc <= redirect_pc;
      end
      half    <= 1'b0;
      pend    <= 1'b0;  // late rdata is ignored
      valid_q <= 1'b0;
    end else begin
      pend <= fetch_grant;
      if (fetch_grant) begin
        pc   <= pc + 1'b1;
        half <= !half;
      end
      if (load_pair) begin
        valid_q <= 1'b1;
      end else if (valid_q && instr_ready) begin
        valid_q <= 1'b0;  // handed to execute
      end
    end
  end

  // payload regs, no reset
  always_ff @(posedge clk) begin
    if (fetch_grant) begin
      pend_half <= half;
      if (!half) begin
        pair_pc <= pc;
      end
    end
    if (pend && !pend_half) begin
      word1_q <= rdata;
    end
    if (load_pair) begin
      instr_word1 <= word1_q;
      instr_word2 <= rdata;
      instr_pc    <= pair_pc;
    end
  end

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
  input  logic            clk,
  input  logic            rst,
  input  logic            instr_valid,
  input  core_pkg::word_t instr_word1,
  input  core_pkg::word_t instr_word2,
  input  core_pkg::addr_t instr_pc,
  output logic            instr_ready,
  output logic            ex_en,
  output logic            ex_we,
  output core_pkg::addr_t ex_addr,
  output core_pkg::word_t ex_wdata,
  input  core_pkg::word_t rdata,
  output logic            redirect,
  output core_pkg::addr_t redirect_pc,
  output logic            halt
);

  import core_pkg::*;

  word_t    regs [NUM_REGS];  // undefined until written
  opcode_t  opcode;
  reg_idx_t rd;               // low 5 bits of the low byte
  operand_u operand;          // word 2, imm or addr view
  logic     accept;           // transfer from fetch this cycle
  logic     is_halt;
  logic     is_jmp;
  logic     is_load;
  logic     is_store;
  logic     is_num;
  logic     load_busy;        // second cycle of RAM2REG
  reg_idx_t load_reg;         // target of the pending load

  assign opcode  = instr_word1[15:8];
  assign rd      = instr_word1[4:0];
  assign operand = instr_word2;

  // instr_pc is only carried along for jump-relative debug, not decoded

  always_comb begin
    is_halt  = 1'b0;
    is_jmp   = 1'b0;
    is_load  = 1'b0;
    is_store = 1'b0;
    is_num   = 1'b0;
    case (opcode)
      OPCODE_HALT:    is_halt  = 1'b1;
      OPCODE_JMP:     is_jmp   = 1'b1;
      OPCODE_RAM2REG: is_load  = 1'b1;
      OPCODE_REG2RAM: is_store = 1'b1;
      OPCODE_NUM2REG: is_num   = 1'b1;
      default:        ;  // unknown opcode, no effect
    endcase
  end

  // stall during load return, and while a jump or halt is taking effect
  assign instr_ready = !load_busy && !redirect && !halt;
  assign accept      = instr_valid && instr_ready;

  // memory request goes out in the accept cycle, wins over fetch
  assign ex_en    = accept && (is_load || is_store);
  assign ex_we    = accept && is_store;
  assign ex_addr  = operand.mem.addr;
  assign ex_wdata = regs[rd];

  always_ff @(posedge clk) begin
    if (rst) begin
      load_busy <= 1'b0;
      redirect  <= 1'b0;
      halt      <= 1'b0;
    end else begin
      load_busy <= accept && is_load;
      redirect  <= accept && is_jmp;   // one-cycle pulse
      halt      <= accept && is_halt;  // one-cycle pulse
    end
  end

  always_ff @(posedge clk) begin
    if (accept && is_load) begin
      load_reg <= rd;
    end
    if (accept && is_jmp) begin
      redirect_pc <= operand.mem.addr;  // absolute target
    end
  end

  // one write port, load return or immediate
  always_ff @(posedge clk) begin
    if (load_busy) begin
      regs[load_reg] <= rdata;
    end else if (accept && is_num) begin
      regs[rd] <= operand.imm;
    end
  end

endmodule

/* logic/axil_host_port.sv */
`timescale 1ns/1ps

module axil_host_port (
  input  logic            clk,
  input  logic            rst,
  input  logic [11:0]     awaddr,
  input  logic            awvalid,
  output logic            awready,
  input  logic [31:0]     wdata,
  input  logic [3:0]      wstrb,
  input  logic            wvalid,
  output logic            wready,
  output logic [1:0]      bresp,
  output logic            bvalid,
  input  logic            bready,
  input  logic [11:0]     araddr,
  input  logic            arvalid,
  output logic            arready,
  output logic [31:0]     rdata,
  output logic [1:0]      rresp,
  output logic            rvalid,
  input  logic            rready,
  output logic            running,
  output logic            start,
  input  logic            halt,
  output logic            host_en,
  output logic            host_we,
  output core_pkg::addr_t host_addr,
  output core_pkg::word_t host_wdata,
  input  core_pkg::word_t mem_rdata
);

  import core_pkg::*;

  logic        aw_got;       // AW accepted, waiting for W
  logic        w_got;        // W accepted, waiting for AW
  logic [11:0] aw_addr_q;
  word_t       w_data_q;     // low 16 bits only
  logic [1:0]  w_strb_q;     // strobes of the low half
  logic        aw_take;
  logic        w_take;
  logic        ar_take;
  logic        wr_exec;      // both halves present, act now
  logic        wr_is_mem;
  logic        wr_is_ctrl;
  logic        wr_mem_fire;
  logic        start_hit;
  logic        ar_is_mem;
  logic        rd_mem_fire;
  logic        rd_pend;      // memory read in flight
  logic [11:0] ar_addr_q;
  logic        rd_mem_q;     // read targets memory
  logic        rd_err_q;     // memory read while running
  logic        rd_is_ctrl;

  assign aw_take = awvalid && awready;
  assign w_take  = wvalid && wready;
  assign ar_take = arvalid && arready;

  // held response blocks the next write
  assign awready = !aw_got && !bvalid;
  assign wready  = !w_got && !bvalid;
  // write owns the memory port in its exec cycle
  assign arready = !rd_pend && !rvalid && !wr_exec;

  assign wr_exec    = aw_got && w_got;
  assign wr_is_mem  = aw_addr_q[11:8] == 4'h0;
  assign wr_is_ctrl = aw_addr_q[11:2] == CTRL_ADDR[11:2];
  assign ar_is_mem  = araddr[11:8] == 4'h0;
  assign rd_is_ctrl = ar_addr_q[11:2] == CTRL_ADDR[11:2];

  assign wr_mem_fire = wr_exec && wr_is_mem && !running && (w_strb_q != 2'b00);
  assign rd_mem_fire = ar_take && ar_is_mem && !running;
  assign start_hit   = wr_is_ctrl && w_strb_q[0] && w_data_q[0] && !running;

  assign host_en    = wr_mem_fire || rd_mem_fire;
  assign host_we    = wr_mem_fire;
  assign host_addr  = wr_exec ? aw_addr_q[7:2] : araddr[7:2];  // byte -> word
  assign host_wdata = w_data_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      aw_got  <= 1'b0;
      w_got   <= 1'b0;
      bvalid  <= 1'b0;
      rd_pend <= 1'b0;
      rvalid  <= 1'b0;
      running <= 1'b0;
      start   <= 1'b0;
    end else begin
      start <= 1'b0;
      if (aw_take) begin
        aw_got <= 1'b1;
      end
      if (w_take) begin
        w_got <= 1'b1;
      end
      if (wr_exec) begin
        aw_got <= 1'b0;
        w_got  <= 1'b0;
        bvalid <= 1'b1;
        if (start_hit) begin
          start   <= 1'b1;  // pulse, fetch reloads its pc
          running <= 1'b1;
        end
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (halt) begin
        running <= 1'b0;
      end
      if (ar_take) begin
        rd_pend <= 1'b1;
      end
      if (rd_pend) begin
        rd_pend <= 1'b0;
        rvalid  <= 1'b1;  // two cycles after AR
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_take) begin
      aw_addr_q <= awaddr;
    end
    if (w_take) begin
      w_data_q <= wdata[15:0];
      w_strb_q <= wstrb[1:0];
    end
    if (wr_exec) begin
      bresp <= (wr_is_mem && running) ? RESP_SLVERR : RESP_OKAY;
    end
    if (ar_take) begin
      ar_addr_q <= araddr;
      rd_mem_q  <= ar_is_mem;
      rd_err_q  <= ar_is_mem && running;
    end
    if (rd_pend) begin
      rresp <= rd_err_q ? RESP_SLVERR : RESP_OKAY;
      if (rd_err_q) begin
        rdata <= 32'h0;
      end else if (rd_mem_q) begin
        rdata <= {16'h0, mem_rdata};  // zero-extended word
      end else if (rd_is_ctrl) begin
        rdata <= {31'h0, running};
      end else begin
        rdata <= 32'h0;  // unmapped
      end
    end
  end

endmodule

/* logic/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
  input  logic        clk,
  input  logic        rst,
  input  logic [11:0] awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [11:0] araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready
);

  import core_pkg::*;

  logic  running;      // run bit
  logic  start;        // pulse from a control write
  logic  halt;         // pulse from HALT
  logic  host_en;
  logic  host_we;
  addr_t host_addr;
  word_t host_wdata;
  logic  ex_en;
  logic  ex_we;
  addr_t ex_addr;
  word_t ex_wdata;
  logic  fetch_en;
  addr_t fetch_addr;
  logic  fetch_grant;
  word_t mem_rdata;    // shared read bus
  logic  instr_valid;
  logic  instr_ready;
  word_t instr_word1;
  word_t instr_word2;
  addr_t instr_pc;
  logic  redirect;
  addr_t redirect_pc;

  axil_host_port axil_host_port_inst (
    .clk        (clk),
    .rst        (rst),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .running    (running),
    .start      (start),
    .halt       (halt),
    .host_en    (host_en),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .mem_rdata  (mem_rdata)
  );

  fetch_stage fetch_stage_inst (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .running     (running),
    .fetch_en    (fetch_en),
    .fetch_addr  (fetch_addr),
    .fetch_grant (fetch_grant),
    .rdata       (mem_rdata),
    .instr_valid (instr_valid),
    .instr_word1 (instr_word1),
    .instr_word2 (instr_word2),
    .instr_pc    (instr_pc),
    .instr_ready (instr_ready),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  execute_stage execute_stage_inst (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr_word1 (instr_word1),
    .instr_word2 (instr_word2),
    .instr_pc    (instr_pc),
    .instr_ready (instr_ready),
    .ex_en       (ex_en),
    .ex_we       (ex_we),
    .ex_addr     (ex_addr),
    .ex_wdata    (ex_wdata),
    .rdata       (mem_rdata),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .halt        (halt)
  );

  word_ram word_ram_inst (
    .clk         (clk),
    .host_en     (host_en),
    .host_we     (host_we),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .ex_en       (ex_en),
    .ex_we       (ex_we),
    .ex_addr     (ex_addr),
    .ex_wdata    (ex_wdata),
    .fetch_en    (fetch_en),
    .fetch_addr  (fetch_addr),
    .rdata       (mem_rdata),
    .fetch_grant (fetch_grant)
  );

endmodule

/* testbench/cpu_props.sv */
`timescale 1ns/1ps

module cpu_props (
  input logic       clk,
  input logic       rst,
  input logic       awvalid,
  input logic       awready,
  input logic       wvalid,
  input logic       wready,
  input logic [1:0] bresp,
  input logic       bvalid,
  input logic       bready,
  input logic       arvalid,
  input logic       arready,
  input logic       rvalid,
  input logic       rready,
  input logic       running
);

  import core_pkg::*;

  int fail_count = 0;  // summed into the testbench closing line

  // host side valids hold until taken
  aw_hold: assert property (@(posedge clk) disable iff (rst) awvalid && !awready |=> awvalid)
    else begin
      fail_count++;
      $error("awvalid dropped before awready");
    end
  w_hold: assert property (@(posedge clk) disable iff (rst) wvalid && !wready |=> wvalid)
    else begin
      fail_count++;
      $error("wvalid dropped before wready");
    end
  ar_hold: assert property (@(posedge clk) disable iff (rst) arvalid && !arready |=> arvalid)
    else begin
      fail_count++;
      $error("arvalid dropped before arready");
    end

  // slave side responses
  b_hold: assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
    else begin
      fail_count++;
      $error("bvalid dropped before bready");
    end
  r_hold: assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid)
    else begin
      fail_count++;
      $error("rvalid dropped before rready");
    end

  // checked on the first cycle out of reset
  resp_idle: assert property (@(posedge clk) rst |=> !bvalid && !rvalid)
    else begin
      fail_count++;
      $error("bvalid or rvalid set after reset");
    end

  // write accepted while halted must answer OKAY
  b_okay: assert property (@(posedge clk) disable iff (rst)
                           bvalid && !$past(bvalid) && !$past(running) |-> bresp == RESP_OKAY)
    else begin
      fail_count++;
      $error("error response to a write while halted");
    end

endmodule

bind cpu_top cpu_props cpu_props_inst (
  .clk     (clk),
  .rst     (rst),
  .awvalid (awvalid),
  .awready (awready),
  .wvalid  (wvalid),
  .wready  (wready),
  .bresp   (bresp),
  .bvalid  (bvalid),
  .bready  (bready),
  .arvalid (arvalid),
  .arready (arready),
  .rvalid  (rvalid),
  .rready  (rready),
  .running (running)
);

/* testbench/tb_cpu_top.sv */
`timescale 1ns/1ps

module tb_cpu_top;

  localparam int          TIMEOUT    = 200;     // cycles per wait loop
  localparam int          PROG_BASE  = 46;      // first fetched word
  localparam logic [11:0] CTRL       = 12'h100;
  localparam logic [7:0]  OP_HALT    = 8'd0;
  localparam logic [7:0]  OP_JMP     = 8'd1;
  localparam logic [7:0]  OP_RAM2REG = 8'd2;
  localparam logic [7:0]  OP_REG2RAM = 8'd3;
  localparam logic [7:0]  OP_NUM2REG = 8'd4;
  localparam logic [7:0]  OP_UNKNOWN = 8'h7f;
  localparam logic [1:0]  OKAY       = 2'b00;
  localparam logic [1:0]  SLVERR     = 2'b10;

  logic        clk;
  logic        rst;
  logic [11:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [11:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  int          errors;
  int          timeouts;
  logic [31:0] lfsr;  // galois state

  cpu_top cpu_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // one lfsr step per bit taken
  function automatic logic [15:0] rand_word();
    logic [15:0] w;
    for (int i = 0; i < 16; i++) begin
      w[i] = lfsr[0];
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return w;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else begin
        $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
        errors++;
      end
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (2) @(negedge clk);  // two rising edges in reset
    rst = 1'b0;
  endtask

  // starts and ends on a falling edge
  task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    int   n;
    logic aw_hit;
    logic w_hit;
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = 4'hf;
    wvalid  = 1'b1;
    n = 0;
    while ((awvalid || wvalid) && n < TIMEOUT) begin
      #1;  // ready settled
      aw_hit = awvalid && awready;
      w_hit  = wvalid && wready;
      @(negedge clk);  // handshake done at the rising edge
      if (aw_hit) begin
        awvalid = 1'b0;
      end
      if (w_hit) begin
        wvalid = 1'b0;
      end
      n++;
    end
    if (awvalid || wvalid) begin
      $display("timeout: write to 0x%h was not accepted", addr);
      timeouts++;
      awvalid = 1'b0;
      wvalid  = 1'b0;
    end
    n = 0;
    #1;
    while (!bvalid && n < TIMEOUT) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (!bvalid) begin
      $display("timeout: no write response for 0x%h", addr);
      timeouts++;
    end
    resp = bresp;
    @(negedge clk);
    bready = 1'b1;  // response held a cycle before it is taken
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int   n;
    logic hit;
    araddr  = addr;
    arvalid = 1'b1;
    n = 0;
    while (arvalid && n < TIMEOUT) begin
      #1;
      hit = arready;
      @(negedge clk);
      if (hit) begin
        arvalid = 1'b0;
      end
      n++;
    end
    if (arvalid) begin
      $display("timeout: read of 0x%h was not accepted", addr);
      timeouts++;
      arvalid = 1'b0;
    end
    n = 0;
    #1;
    while (!rvalid && n < TIMEOUT) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (!rvalid) begin
      $display("timeout: no read data for 0x%h", addr);
      timeouts++;
    end
    data = rdata;
    resp = rresp;
    @(negedge clk);
    rready = 1'b1;  // data held a cycle before it is taken
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic write_word(input int idx, input logic [15:0] value);
    logic [1:0] resp;
    axi_write(12'(idx * 4), {16'h0, value}, resp);
    check_value("bresp", {30'h0, resp}, {30'h0, OKAY});
  endtask

  task automatic expect_word(input int idx, input logic [15:0] exp);
    logic [31:0] data;
    logic [1:0]  resp;
    axi_read(12'(idx * 4), data, resp);
    check_value("rresp", {30'h0, resp}, {30'h0, OKAY});
    check_value("rdata", data, {16'h0, exp});  // zero-extended word
  endtask

  // slot n occupies words base+2n and base+2n+1
  task automatic load_instr(input int slot, input logic [7:0] op, input logic [4:0] rnum,
                            input logic [15:0] operand);
    write_word(PROG_BASE + 2 * slot, {op, 3'b000, rnum});
    write_word(PROG_BASE + 2 * slot + 1, operand);
  endtask

  task automatic wait_halt();
    logic [31:0] data;
    logic [1:0]  resp;
    int          n;
    n = 0;
    data = 32'h1;
    while (data[0] !== 1'b0 && n < TIMEOUT) begin
      axi_read(CTRL, data, resp);
      n++;
    end
    if (data[0] !== 1'b0) begin
      $display("timeout: run bit still set, program did not halt");
      timeouts++;
    end
  endtask

  task automatic run_program();
    logic [1:0] resp;
    axi_write(CTRL, 32'h1, resp);  // start
    check_value("bresp", {30'h0, resp}, {30'h0, OKAY});
    wait_halt();
  endtask

  initial begin
    int          probe [4];
    logic [15:0] rnd [4];
    logic [15:0] v;
    logic [15:0] w;
    logic [15:0] x;
    logic [15:0] keep;
    logic [31:0] data;
    logic [1:0]  resp;
    probe    = '{0, 17, 40, 63};
    errors   = 0;
    timeouts = 0;
    lfsr     = 32'h4976_f101;
    awaddr   = 12'h0;
    awvalid  = 1'b0;
    wdata    = 32'h0;
    wstrb    = 4'h0;
    wvalid   = 1'b0;
    bready   = 1'b0;
    araddr   = 12'h0;
    arvalid  = 1'b0;
    rready   = 1'b0;
    apply_reset();

    // control register idle and memory readback
    axi_read(CTRL, data, resp);
    check_value("ctrl rdata", data, 32'h0);
    for (int i = 0; i < 4; i++) begin
      rnd[i] = rand_word();
      write_word(probe[i], rnd[i]);
    end
    for (int i = 0; i < 4; i++) begin
      expect_word(probe[i], rnd[i]);
    end

    // immediate to register then register to memory
    v = rand_word();
    write_word(10, ~v);
    load_instr(0, OP_NUM2REG, 5'd3, v);
    load_instr(1, OP_REG2RAM, 5'd3, 16'd10);
    load_instr(2, OP_HALT, 5'd0, 16'd0);
    run_program();
    expect_word(10, v);

    // memory to register and back
    w = rand_word();
    write_word(20, w);
    write_word(21, ~w);
    load_instr(0, OP_RAM2REG, 5'd7, 16'd20);
    load_instr(1, OP_REG2RAM, 5'd7, 16'd21);
    load_instr(2, OP_HALT, 5'd0, 16'd0);
    run_program();
    expect_word(21, w);
    expect_word(20, w);

    // jump skips the store
    x = rand_word();
    write_word(25, x);
    load_instr(0, OP_NUM2REG, 5'd9, ~x);
    load_instr(1, OP_JMP, 5'd0, 16'(PROG_BASE + 6));
    load_instr(2, OP_REG2RAM, 5'd9, 16'd25);
    load_instr(3, OP_HALT, 5'd0, 16'd0);
    run_program();
    expect_word(25, x);

    // host memory access refused during a tight loop
    keep = rand_word();
    write_word(30, keep);
    load_instr(0, OP_JMP, 5'd0, 16'(PROG_BASE));
    axi_write(CTRL, 32'h1, resp);
    check_value("bresp", {30'h0, resp}, {30'h0, OKAY});
    axi_write(12'(30 * 4), {16'h0, ~keep}, resp);
    check_value("bresp", {30'h0, resp}, {30'h0, SLVERR});
    axi_read(12'(30 * 4), data, resp);
    check_value("rresp", {30'h0, resp}, {30'h0, SLVERR});
    axi_read(CTRL, data, resp);
    check_value("ctrl rdata", data, 32'h1);  // still looping
    apply_reset();
    axi_read(CTRL, data, resp);
    check_value("ctrl rdata", data, 32'h0);
    expect_word(30, keep);  // memory keeps contents over reset

    // unknown opcode is a no-op
    load_instr(0, OP_UNKNOWN, 5'd3, 16'd30);
    load_instr(1, OP_HALT, 5'd0, 16'd0);
    run_program();
    expect_word(10, v);
    expect_word(21, w);
    expect_word(25, x);
    expect_word(30, keep);

    $display("errors: checks %0d, timeouts %0d, assertions %0d", errors, timeouts,
             cpu_top_inst.cpu_props_inst.fail_count);
    if (errors == 0 && timeouts == 0 && cpu_top_inst.cpu_props_inst.fail_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
logic/core_pkg.sv
logic/word_ram.sv
logic/fetch_stage.sv
logic/execute_stage.sv
logic/axil_host_port.sv
logic/cpu_top.sv
testbench/cpu_props.sv
testbench/tb_cpu_top.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the testbench with verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu_top -f flist.f; then
  echo "build failed"
  exit 1
fi

# raise the error limit so assertion failures reach the closing summary
output=$(./obj_dir/Vtb_cpu_top +verilator+error+limit+1000)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
